// File: hw/nic_defines.svh
`ifndef NIC_DEFINES_SVH
`define NIC_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Controller identity

// MAC address split into vendor part and per-board part
`define NIC_MAC_OUI     24'hEC3F05
`define NIC_MAC_NIC     24'h000001

`define NIC_PID         16'hABCD
`define NIC_VID         16'h8086
`define NIC_SUB_PID     16'h6120
`define NIC_SUB_VID     16'hFACE

////////////////////////////////////////////////////////////////////////////
// Image layout

// Sum of all image words, checksum word included
`define NIC_CHECKSUM    16'hBABA

`define NIC_IMAGE_WORDS 64

////////////////////////////////////////////////////////////////////////////
// Microwire front end

// Flops between the pins and the decoder logic
`define MW_SYNC_STAGES  2

`endif

// File: hw/mw_pkg.sv
`default_nettype none

package mw_pkg;

	// Counts bits of a field or of one data word
	typedef logic [3:0] mw_bitcnt_t;

	// Opcode bits following the start bit
	typedef enum logic [1:0] {
		MW_OP_MISC  = 2'b00,
		MW_OP_WRITE = 2'b01,
		MW_OP_READ  = 2'b10,
		MW_OP_ERASE = 2'b11
	} mw_opcode_e;

	typedef enum logic [2:0] {
		MW_IDLE,
		MW_START,
		MW_OPCODE,
		MW_ADDR,
		MW_READ,
		MW_IGNORE
	} mw_state_e;

	// Synchronized pin view shared by decoder and shifter
	typedef struct packed {
		logic sel;
		logic sk_rise;
		logic sk_fall;
	} mw_strobe_t;

endpackage

`default_nettype wire

// File: hw/nvm_pkg.sv
`default_nettype none

`include "nic_defines.svh"

package nvm_pkg;

	typedef logic [7:0]  nvm_addr_t;
	typedef logic [15:0] nvm_word_t;

	localparam int NVM_WORDS = `NIC_IMAGE_WORDS;
	localparam int NVM_IDX_W = $clog2(NVM_WORDS);

	typedef logic [NVM_IDX_W-1:0]      nvm_idx_t;
	typedef nvm_word_t [NVM_WORDS-1:0] nvm_image_t;

	// Unprogrammed cells
	localparam nvm_word_t NVM_BLANK = 16'hFFFF;

	localparam nvm_addr_t OFS_MAC0     = 8'h00;
	localparam nvm_addr_t OFS_MAC1     = 8'h01;
	localparam nvm_addr_t OFS_MAC2     = 8'h02;
	localparam nvm_addr_t OFS_SUB_PID  = 8'h0B;
	localparam nvm_addr_t OFS_SUB_VID  = 8'h0C;
	localparam nvm_addr_t OFS_PID      = 8'h0D;
	localparam nvm_addr_t OFS_VID      = 8'h0E;
	localparam nvm_addr_t OFS_CHECKSUM = 8'h3F;

	typedef struct packed {
		logic      valid;
		nvm_addr_t addr;
	} nvm_req_t;

	typedef struct packed {
		logic      valid;
		nvm_word_t data;
	} nvm_rsp_t;

	function automatic nvm_image_t build_image();
		nvm_image_t  img;
		nvm_word_t   sum;
		logic [23:0] oui;
		logic [23:0] nic;
		img = '0;
		oui = `NIC_MAC_OUI;
		nic = `NIC_MAC_NIC;
		// MAC bytes go low byte first within each word
		img[OFS_MAC0]    = {oui[15:8], oui[23:16]};
		img[OFS_MAC1]    = {nic[23:16], oui[7:0]};
		img[OFS_MAC2]    = {nic[7:0], nic[15:8]};
		img[OFS_SUB_PID] = `NIC_SUB_PID;
		img[OFS_SUB_VID] = `NIC_SUB_VID;
		img[OFS_PID]     = `NIC_PID;
		img[OFS_VID]     = `NIC_VID;
		sum = '0;
		for (int i = 0; i < NVM_WORDS - 1; i++) begin
			sum = sum + img[i];
		end
		img[OFS_CHECKSUM] = `NIC_CHECKSUM - sum;
		return img;
	endfunction

endpackage

`default_nettype wire

// File: hw/mw_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "nic_defines.svh"

module mw_cmd_decoder (
	input  logic               clk_i,
	input  logic               arst_n_i,
	input  logic               sk_i,
	input  logic               cs_i,
	input  logic               di_i,
	input  logic               next_i,
	output mw_pkg::mw_strobe_t strb_o,
	output nvm_pkg::nvm_req_t  req_o
);

	import mw_pkg::*;
	import nvm_pkg::*;

	localparam int SYNC_N = `MW_SYNC_STAGES;

	// Each stage holds {sk, cs, di}
	logic [SYNC_N-1:0][2:0] pin_sync;
	logic                   sk_s;
	logic                   cs_s;
	logic                   di_s;
	logic                   sk_prev;
	logic                   sk_rise;
	logic                   sk_fall;

	mw_state_e  state;
	mw_opcode_e opcode;
	mw_bitcnt_t bit_cnt;
	nvm_addr_t  addr_q;
	nvm_addr_t  addr_in;
	logic       last_bit;
	logic       rd_first;
	logic       rd_next;

	////////////////////////////////////////////////////////////////////////////
	// Pin synchronizer and SK edge detect

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pin_sync <= '0;
			sk_prev  <= 1'b0;
		end else begin
			pin_sync <= {pin_sync[SYNC_N-2:0], {sk_i, cs_i, di_i}};
			sk_prev  <= sk_s;
		end
	end

	assign {sk_s, cs_s, di_s} = pin_sync[SYNC_N-1];
	assign sk_rise = sk_s & ~sk_prev;
	assign sk_fall = ~sk_s & sk_prev;
	assign strb_o  = '{sel: cs_s, sk_rise: sk_rise, sk_fall: sk_fall};

	////////////////////////////////////////////////////////////////////////////
	// Command framing

	assign addr_in  = {addr_q[6:0], di_s};
	assign last_bit = (bit_cnt == mw_bitcnt_t'(7));
	assign rd_first = (state == MW_ADDR) && sk_rise && last_bit && (opcode == MW_OP_READ);
	assign rd_next  = (state == MW_READ) && next_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state   <= MW_IDLE;
			opcode  <= MW_OP_MISC;
			bit_cnt <= '0;
			addr_q  <= '0;
		end else if (!cs_s) begin
			state <= MW_IDLE;
		end else begin
			case (state)
				MW_IDLE: state <= MW_START;
				// Leading zeros before the start bit are skipped
				MW_START: if (sk_rise && di_s) begin
					state   <= MW_OPCODE;
					bit_cnt <= '0;
				end
				MW_OPCODE: if (sk_rise) begin
					opcode  <= mw_opcode_e'({opcode[0], di_s});
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == mw_bitcnt_t'(1)) begin
						state   <= MW_ADDR;
						bit_cnt <= '0;
					end
				end
				MW_ADDR: if (sk_rise) begin
					addr_q  <= addr_in;
					bit_cnt <= bit_cnt + 1'b1;
					if (last_bit) begin
						state <= (opcode == MW_OP_READ) ? MW_READ : MW_IGNORE;
					end
				end
				MW_READ: if (next_i) begin
					addr_q <= addr_q + 1'b1;
				end
				// Held until CS drops
				MW_IGNORE: ;
				default: state <= MW_IDLE;
			endcase
		end
	end

	assign req_o.valid = rd_first | rd_next;
	assign req_o.addr  = rd_first ? addr_in : nvm_addr_t'(addr_q + 1'b1);

	a_req_in_frame: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		req_o.valid |-> strb_o.sel);

endmodule

`default_nettype wire

// File: hw/nvm_image_rom.sv
`timescale 1ns/1ps
`default_nettype none

module nvm_image_rom (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  nvm_pkg::nvm_req_t req_i,
	output nvm_pkg::nvm_rsp_t rsp_o
);

	import nvm_pkg::*;

	localparam nvm_image_t IMAGE = build_image();

	nvm_idx_t  idx;
	logic      in_range;
	logic      valid_q;
	nvm_word_t data_q;

	////////////////////////////////////////////////////////////////////////////
	// Address decode

	assign idx      = req_i.addr[NVM_IDX_W-1:0];
	// Upper address bits set means beyond the programmed image
	assign in_range = (req_i.addr[$bits(nvm_addr_t)-1:NVM_IDX_W] == '0);

	////////////////////////////////////////////////////////////////////////////
	// Registered read port

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= req_i.valid;
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_i.valid) begin
			data_q <= in_range ? IMAGE[idx] : NVM_BLANK;
		end
	end

	assign rsp_o = '{valid: valid_q, data: data_q};

	a_req_addr_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		req_i.valid |-> !$isunknown(req_i.addr));

endmodule

`default_nettype wire

// File: hw/mw_data_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module mw_data_shifter (
	input  logic               clk_i,
	input  logic               arst_n_i,
	input  mw_pkg::mw_strobe_t strb_i,
	input  nvm_pkg::nvm_rsp_t  rsp_i,
	output logic               next_o,
	output logic               do_o,
	output logic               do_oe_o
);

	import mw_pkg::*;
	import nvm_pkg::*;

	nvm_word_t  pf_q;
	logic       pf_full;
	nvm_word_t  sh_q;
	mw_bitcnt_t bit_cnt;
	logic       load;

	// Word boundary once the dummy bit or the last data bit is out
	assign load = strb_i.sk_rise && do_oe_o && (bit_cnt == '0);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pf_full <= 1'b0;
			bit_cnt <= '0;
			next_o  <= 1'b0;
			do_o    <= 1'b0;
			do_oe_o <= 1'b0;
		end else if (!strb_i.sel) begin
			pf_full <= 1'b0;
			bit_cnt <= '0;
			next_o  <= 1'b0;
			do_o    <= 1'b0;
			do_oe_o <= 1'b0;
		end else begin
			next_o <= load;
			if (strb_i.sk_rise) begin
				if (!do_oe_o) begin
					// Dummy zero ahead of the first word
					if (pf_full) begin
						do_o    <= 1'b0;
						do_oe_o <= 1'b1;
					end
				end else if (load) begin
					do_o    <= pf_q[15];
					bit_cnt <= mw_bitcnt_t'(15);
					pf_full <= 1'b0;
				end else begin
					do_o    <= sh_q[15];
					bit_cnt <= bit_cnt - 1'b1;
				end
			end
			if (rsp_i.valid) begin
				pf_full <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Prefetch and shift registers

	always_ff @(posedge clk_i) begin
		if (rsp_i.valid) begin
			pf_q <= rsp_i.data;
		end
		if (load) begin
			sh_q <= {pf_q[14:0], 1'b0};
		end else if (strb_i.sk_rise) begin
			sh_q <= {sh_q[14:0], 1'b0};
		end
	end

	a_oe_in_frame: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!strb_i.sel |=> !do_oe_o);

	a_no_overrun: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		rsp_i.valid |-> !pf_full);

	// Host samples on the falling edge, so DO must hold there
	a_do_stable_fall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		strb_i.sk_fall && strb_i.sel |=> $stable(do_o));

endmodule

`default_nettype wire

// File: hw/eeprom_emu.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_emu (
	input  logic clk_i,
	input  logic arst_n_i,
	input  logic sk_i,
	input  logic cs_i,
	input  logic di_i,
	output logic do_o,
	output logic do_oe_o
);

	import mw_pkg::*;
	import nvm_pkg::*;

	mw_strobe_t strb;
	nvm_req_t   req;
	nvm_rsp_t   rsp;
	logic       next;

	mw_cmd_decoder cmd_decoder_i (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.sk_i     (sk_i),
		.cs_i     (cs_i),
		.di_i     (di_i),
		.next_i   (next),
		.strb_o   (strb),
		.req_o    (req)
	);

	nvm_image_rom image_rom_i (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.req_i    (req),
		.rsp_o    (rsp)
	);

	mw_data_shifter data_shifter_i (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.strb_i   (strb),
		.rsp_i    (rsp),
		.next_o   (next),
		.do_o     (do_o),
		.do_oe_o  (do_oe_o)
	);

endmodule

`default_nettype wire

// File: sim/tb_eeprom_emu.sv
`timescale 1ns/1ps
`default_nettype none

`include "nic_defines.svh"

module tb_eeprom_emu;

	// SK half-period in clock cycles
	localparam int HALF = 8;

	logic clk_i;
	logic arst_n_i;
	logic sk_i;
	logic cs_i;
	logic di_i;
	logic do_o;
	logic do_oe_o;

	logic [15:0] ref_img [0:`NIC_IMAGE_WORDS-1];
	integer      seed;

	eeprom_emu UUT (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.sk_i     (sk_i),
		.cs_i     (cs_i),
		.di_i     (di_i),
		.do_o     (do_o),
		.do_oe_o  (do_oe_o)
	);

	always #4 clk_i = ~clk_i;

	////////////////////////////////////////////////////////////////////////////
	// Reference image and checks

	task automatic build_reference();
		logic [23:0] oui;
		logic [23:0] nic;
		logic [15:0] sum;
		oui = `NIC_MAC_OUI;
		nic = `NIC_MAC_NIC;
		for (int i = 0; i < `NIC_IMAGE_WORDS; i++) begin
			ref_img[i] = 16'h0000;
		end
		ref_img[8'h00] = {oui[15:8], oui[23:16]};
		ref_img[8'h01] = {nic[23:16], oui[7:0]};
		ref_img[8'h02] = {nic[7:0], nic[15:8]};
		ref_img[8'h0B] = `NIC_SUB_PID;
		ref_img[8'h0C] = `NIC_SUB_VID;
		ref_img[8'h0D] = `NIC_PID;
		ref_img[8'h0E] = `NIC_VID;
		sum = 16'h0000;
		for (int i = 0; i < `NIC_IMAGE_WORDS - 1; i++) begin
			sum = sum + ref_img[i];
		end
		// Last word tops the sum up to the target
		ref_img[`NIC_IMAGE_WORDS-1] = `NIC_CHECKSUM - sum;
	endtask

	function automatic logic [15:0] expected_word(input logic [7:0] addr);
		if (addr < `NIC_IMAGE_WORDS) begin
			return ref_img[addr];
		end
		return 16'hFFFF;
	endfunction

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input logic [15:0] exp,
			input logic [15:0] act);
		assert (exp === act) else begin
			stop_on_failure($sformatf("error %s: expected %h, actual %h", test, exp, act));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Microwire host

	// One SK period; DO is taken just before SK falls
	task automatic clock_bit(input logic di_val, output logic do_val, output logic oe_val);
		@(posedge clk_i);
		sk_i <= 1'b0;
		di_i <= di_val;
		repeat (HALF - 1) @(posedge clk_i);
		@(posedge clk_i);
		sk_i <= 1'b1;
		repeat (HALF - 1) @(posedge clk_i);
		@(negedge clk_i);
		do_val = do_o;
		oe_val = do_oe_o;
	endtask

	task automatic select();
		@(posedge clk_i);
		sk_i <= 1'b0;
		di_i <= 1'b0;
		cs_i <= 1'b1;
		repeat (HALF - 1) @(posedge clk_i);
	endtask

	task automatic deselect(input string test);
		int cnt;
		@(posedge clk_i);
		sk_i <= 1'b0;
		di_i <= 1'b0;
		cs_i <= 1'b0;
		cnt = 0;
		@(negedge clk_i);
		while (do_oe_o !== 1'b0 && cnt < 8) begin
			@(negedge clk_i);
			cnt++;
		end
		assert (do_oe_o === 1'b0) else begin
			stop_on_failure($sformatf("%s: DO stayed enabled after CS went low", test));
		end
		check_value(test, 16'h0000, {15'h0, do_o});
		repeat (HALF) @(posedge clk_i);
	endtask

	task automatic send_command(input logic [1:0] op, input logic [7:0] addr);
		logic d;
		logic oe;
		clock_bit(1'b1, d, oe);
		for (int i = 1; i >= 0; i--) begin
			clock_bit(op[i], d, oe);
		end
		for (int i = 7; i >= 0; i--) begin
			clock_bit(addr[i], d, oe);
		end
	endtask

	task automatic start_read(input string test, input logic [7:0] addr);
		logic d;
		logic oe;
		select();
		send_command(2'b10, addr);
		clock_bit(1'b0, d, oe);
		check_value({test, " dummy oe"}, 16'h0001, {15'h0, oe});
		check_value({test, " dummy bit"}, 16'h0000, {15'h0, d});
	endtask

	task automatic read_word(input string test, output logic [15:0] w);
		logic d;
		logic oe;
		for (int i = 15; i >= 0; i--) begin
			clock_bit(1'b0, d, oe);
			check_value({test, " oe"}, 16'h0001, {15'h0, oe});
			w[i] = d;
		end
	endtask

	task automatic single_read(input string test, input logic [7:0] addr);
		logic [15:0] w;
		start_read(test, addr);
		read_word(test, w);
		check_value(test, expected_word(addr), w);
		deselect(test);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic reset_state();
		check_value("reset do", 16'h0000, {15'h0, do_o});
		check_value("reset oe", 16'h0000, {15'h0, do_oe_o});
	endtask

	task automatic id_word_reads();
		logic [7:0] addrs [0:6];
		addrs = '{8'h00, 8'h01, 8'h02, 8'h0B, 8'h0C, 8'h0D, 8'h0E};
		foreach (addrs[i]) begin
			single_read($sformatf("single_read@%h", addrs[i]), addrs[i]);
		end
	endtask

	task automatic sequential_image();
		logic [15:0] w;
		logic [15:0] sum;
		sum = 16'h0000;
		start_read("sequential", 8'h00);
		for (int i = 0; i < `NIC_IMAGE_WORDS; i++) begin
			read_word("sequential", w);
			// Checksum word is covered by the sum below
			if (i < `NIC_IMAGE_WORDS - 1) begin
				check_value($sformatf("sequential@%h", i[7:0]), expected_word(i[7:0]), w);
			end
			sum = sum + w;
		end
		deselect("sequential");
		check_value("checksum", `NIC_CHECKSUM, sum);
	endtask

	task automatic range_and_wrap();
		logic [15:0] w;
		logic [7:0]  addr;
		start_read("range", 8'h3E);
		for (int i = 0; i < 4; i++) begin
			addr = 8'h3E + i[7:0];
			read_word("range", w);
			check_value($sformatf("range@%h", addr), expected_word(addr), w);
		end
		deselect("range");
		start_read("wrap", 8'hFF);
		read_word("wrap", w);
		check_value("wrap@ff", 16'hFFFF, w);
		read_word("wrap", w);
		check_value("wrap@00", expected_word(8'h00), w);
		deselect("wrap");
	endtask

	task automatic ignored_commands();
		logic d;
		logic oe;
		select();
		send_command(2'b01, 8'h10);
		// Data that a real part would program
		for (int i = 0; i < 16; i++) begin
			clock_bit(i[0], d, oe);
			check_value("write oe", 16'h0000, {15'h0, oe});
		end
		deselect("write");
		select();
		send_command(2'b11, 8'h05);
		for (int i = 0; i < 4; i++) begin
			clock_bit(1'b0, d, oe);
			check_value("erase oe", 16'h0000, {15'h0, oe});
		end
		deselect("erase");
		single_read("read_after_ignored", 8'h0D);
	endtask

	task automatic random_reads();
		logic [31:0] r;
		logic [7:0]  addr;
		for (int i = 0; i < 20; i++) begin
			r = $random(seed);
			addr = r[7:0];
			single_read($sformatf("random@%h", addr), addr);
		end
	endtask

	initial begin
		clk_i    = 1'b0;
		arst_n_i = 1'b0;
		sk_i     = 1'b0;
		cs_i     = 1'b0;
		di_i     = 1'b0;
		seed     = 32'h53e9;
		build_reference();
		repeat (16) @(posedge clk_i);
		arst_n_i <= 1'b1;
		repeat (4) @(posedge clk_i);
		@(negedge clk_i);
		reset_state();
		id_word_reads();
		sequential_image();
		range_and_wrap();
		ignored_commands();
		random_reads();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: eeprom_emu.f
+incdir+hw
hw/mw_pkg.sv
hw/nvm_pkg.sv
hw/mw_cmd_decoder.sv
hw/nvm_image_rom.sv
hw/mw_data_shifter.sv
hw/eeprom_emu.sv
sim/tb_eeprom_emu.sv

// File: Bender.yml
package:
  name: eeprom_emu

sources:
  - include_dirs:
      - hw
    files:
      - hw/mw_pkg.sv
      - hw/nvm_pkg.sv
      - hw/mw_cmd_decoder.sv
      - hw/nvm_image_rom.sv
      - hw/mw_data_shifter.sv
      - hw/eeprom_emu.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_eeprom_emu.sv
